// File: Makefile
TOP := tb_bicubic_buffer
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: hdl/bank_if.sv
`timescale 1ns/1ps

interface bank_if;
    import bicubic_pkg::*;

    logic       wr_en;
    bank_addr_t wr_addr;
    sub_t       wr_line;
    pixel_t     wdata;
    logic       rd_en;
    bank_addr_t rd_addr;
    sub_t       rd_line;
    // group of four banks on the write side, the other group is read
    logic       wr_half;
    pixel_t     rdata;

    modport ctrl (
        output wr_en, wr_addr, wr_line, wdata,
        output rd_en, rd_addr, rd_line, wr_half,
        input  rdata
    );

    modport banks (
        input  wr_en, wr_addr, wr_line, wdata,
        input  rd_en, rd_addr, rd_line, wr_half,
        output rdata
    );

endinterface

// File: hdl/bicubic_buffer.sv
`timescale 1ns/1ps

module bicubic_buffer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pix_valid,
    output logic                pix_ready,
    input  bicubic_pkg::pixel_t pix_data,
    output logic                win_valid,
    input  logic                win_ready,
    output bicubic_pkg::pixel_t win_data [16],
    input  logic                res_valid,
    output logic                res_ready,
    input  bicubic_pkg::pixel_t res_data,
    output logic                out_valid,
    input  logic                out_ready,
    output bicubic_pkg::pixel_t out_data
);

    bank_if u_bank_bus ();

    window_gen u_window_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .pix_valid(pix_valid),
        .pix_ready(pix_ready),
        .pix_data (pix_data),
        .win_valid(win_valid),
        .win_ready(win_ready),
        .win_data (win_data)
    );

    result_store_ctrl u_store_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .res_valid(res_valid),
        .res_ready(res_ready),
        .res_data (res_data),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_data (out_data),
        .bus      (u_bank_bus.ctrl)
    );

    result_banks u_banks (
        .clk(clk),
        .bus(u_bank_bus.banks)
    );

endmodule

// File: hdl/bicubic_pkg.sv
package bicubic_pkg;

    localparam int img_width  = 11;
    localparam int img_height = 6;
    localparam int pad_cols   = 3;

    // one padded source row as it arrives on the pixel stream
    localparam int row_len = img_width + pad_cols;

    // three rows plus four pixels fill the 4x4 array
    localparam int preload_pixels = 3 * row_len + 4;
    localparam int total_pixels   = (img_height + 3) * row_len;

    // 4 sub-columns per output column
    localparam int bank_depth = 4 * img_width;
    localparam int bank_aw    = $clog2(bank_depth);

    typedef logic [23:0]                         pixel_t;
    typedef logic [9:0]                          col_t;
    typedef logic [9:0]                          row_t;
    typedef logic [bank_aw-1:0]                  bank_addr_t;
    typedef logic [1:0]                          sub_t;
    typedef logic [$clog2(total_pixels + 1)-1:0] pix_cnt_t;

    typedef enum logic [2:0] {
        rd_idle,
        rd_load,
        rd_prime,
        rd_stream,
        rd_last
    } rd_state_t;

endpackage

// File: hdl/line_delay.sv
`timescale 1ns/1ps

module line_delay #(
    parameter int depth = bicubic_pkg::img_width + bicubic_pkg::pad_cols - 4
) (
    input  logic                clk,
    input  logic                shift_en,
    input  bicubic_pkg::pixel_t din,
    output bicubic_pkg::pixel_t dout
);
    import bicubic_pkg::*;

    pixel_t taps [depth];

    always_ff @(posedge clk) begin
        if (shift_en) begin
            taps[0] <= din;
            for (int i = 1; i < depth; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

    // oldest tap feeds the right end of the next array row
    assign dout = taps[depth-1];

endmodule

// File: hdl/result_banks.sv
`timescale 1ns/1ps

module result_banks (
    input logic   clk,
    bank_if.banks bus
);
    import bicubic_pkg::*;

    pixel_t     bank_q [8];
    logic [2:0] rd_sel;

    // bank b is line b%4 of half b/4
    for (genvar b = 0; b < 8; b++) begin : g_bank
        pixel_t     mem [bank_depth];
        pixel_t     q;
        bank_addr_t addr;
        logic       wr_side;

        assign wr_side = bus.wr_half == 1'(b / 4);
        assign addr    = wr_side ? bus.wr_addr : bus.rd_addr;

        always_ff @(posedge clk) begin
            if (bus.wr_en && wr_side && bus.wr_line == sub_t'(b % 4))
                mem[addr] <= bus.wdata;
            if (bus.rd_en && !wr_side && bus.rd_line == sub_t'(b % 4))
                q <= mem[addr];
        end

        assign bank_q[b] = q;
    end

    // select follows the read by one cycle
    always_ff @(posedge clk) begin
        if (bus.rd_en)
            rd_sel <= {~bus.wr_half, bus.rd_line};
    end

    assign bus.rdata = bank_q[rd_sel];

endmodule

// File: hdl/result_store_ctrl.sv
`timescale 1ns/1ps

module result_store_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                res_valid,
    output logic                res_ready,
    input  bicubic_pkg::pixel_t res_data,
    output logic                out_valid,
    input  logic                out_ready,
    output bicubic_pkg::pixel_t out_data,
    bank_if.ctrl                bus
);
    import bicubic_pkg::*;

    rd_state_t  rd_state;
    sub_t       wr_sub;
    sub_t       wr_line;
    col_t       wr_col;
    logic       wr_half;
    logic       wr_full;
    logic       res_en;
    logic       res_hs;
    logic       row_end;
    logic       swap;
    bank_addr_t rd_addr;
    sub_t       rd_line;
    logic       rd_pend;
    logic       rd_issue;
    logic       rd_final;
    row_t       rd_rows;

    assign res_hs  = res_valid && res_ready;
    assign row_end = res_hs && wr_sub == 2'd3 && wr_line == 2'd3
                  && wr_col == col_t'(img_width - 1);
    // halves trade places only while the read side is idle
    assign swap    = (row_end || wr_full) && rd_state == rd_idle;

    assign res_ready = res_en && !wr_full && rd_rows != row_t'(img_height);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_en  <= 1'b0;
            wr_sub  <= '0;
            wr_line <= '0;
            wr_col  <= '0;
            wr_half <= 1'b0;
            wr_full <= 1'b0;
        end else begin
            res_en <= 1'b1;
            // result k goes to sub-line k/4, sub-column k%4
            if (res_hs) begin
                wr_sub <= wr_sub + 1'b1;
                if (wr_sub == 2'd3) begin
                    wr_line <= wr_line + 1'b1;
                    if (wr_line == 2'd3)
                        wr_col <= (wr_col == col_t'(img_width - 1)) ? '0 : wr_col + 1'b1;
                end
            end
            if (swap)
                wr_half <= ~wr_half;
            wr_full <= (wr_full || row_end) && !swap;
        end
    end

    assign bus.wr_en   = res_hs;
    assign bus.wr_addr = bank_addr_t'({wr_col, wr_sub});
    assign bus.wr_line = wr_line;
    assign bus.wdata   = res_data;
    assign bus.wr_half = wr_half;

    // one read in flight, and only into a free output register
    assign rd_issue = (rd_state == rd_prime || rd_state == rd_stream)
                   && !rd_pend && (!out_valid || out_ready);
    assign rd_final = rd_line == 2'd3 && rd_addr == bank_addr_t'(bank_depth - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state <= rd_idle;
            rd_addr  <= '0;
            rd_line  <= '0;
            rd_pend  <= 1'b0;
            rd_rows  <= '0;
        end else begin
            rd_pend <= rd_issue;
            case (rd_state)
                rd_idle: begin
                    if (swap)
                        rd_state <= rd_load;
                end
                rd_load: begin
                    rd_addr  <= '0;
                    rd_line  <= '0;
                    rd_state <= rd_prime;
                end
                rd_prime: begin
                    if (rd_issue)
                        rd_state <= rd_stream;
                end
                rd_stream: begin
                    if (rd_issue && rd_final)
                        rd_state <= rd_last;
                end
                rd_last: begin
                    // last word landed, banks are free to swap
                    if (!rd_pend) begin
                        rd_state <= rd_idle;
                        rd_rows  <= rd_rows + 1'b1;
                    end
                end
                default: rd_state <= rd_idle;
            endcase
            if (rd_issue) begin
                if (rd_addr == bank_addr_t'(bank_depth - 1)) begin
                    rd_addr <= '0;
                    rd_line <= rd_line + 1'b1;
                end else begin
                    rd_addr <= rd_addr + 1'b1;
                end
            end
        end
    end

    assign bus.rd_en   = rd_issue;
    assign bus.rd_addr = rd_addr;
    assign bus.rd_line = rd_line;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            out_valid <= 1'b0;
        else if (rd_pend)
            out_valid <= 1'b1;
        else if (out_ready)
            out_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rd_pend)
            out_data <= bus.rdata;
    end

endmodule

// File: hdl/window_gen.sv
`timescale 1ns/1ps

module window_gen (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pix_valid,
    output logic                pix_ready,
    input  bicubic_pkg::pixel_t pix_data,
    output logic                win_valid,
    input  logic                win_ready,
    output bicubic_pkg::pixel_t win_data [16]
);
    import bicubic_pkg::*;

    pixel_t   ld_out [3];
    pix_cnt_t pix_cnt;
    col_t     col;
    row_t     row;
    logic     started;
    logic     preloaded;
    logic     in_done;
    logic     active;
    logic     in_window;
    logic     pix_take;
    logic     shift_en;

    assign preloaded = pix_cnt >= pix_cnt_t'(preload_pixels);
    assign in_done   = pix_cnt == pix_cnt_t'(total_pixels);
    assign active    = started && preloaded && row < row_t'(img_height);
    assign in_window = col < col_t'(img_width);

    // source used up, the last steps of the final row run without pixels
    assign win_valid = active && in_window && (pix_valid || in_done);

    always_comb begin
        if (in_done)
            pix_ready = 1'b0;
        else if (active)
            pix_ready = in_window ? win_valid && win_ready : pix_valid;
        else
            pix_ready = started && !preloaded;
    end

    assign pix_take = pix_valid && pix_ready;
    assign shift_en = pix_take || (in_done && active && (!in_window || win_ready));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            started <= 1'b0;
            pix_cnt <= '0;
            col     <= '0;
            row     <= '0;
        end else begin
            started <= 1'b1;
            if (pix_take)
                pix_cnt <= pix_cnt + 1'b1;
            // three padding steps close each row
            if (shift_en && active) begin
                if (col == col_t'(row_len - 1)) begin
                    col <= '0;
                    row <= row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    // p1..p4 oldest row, p16 newest pixel
    always_ff @(posedge clk) begin
        if (shift_en) begin
            for (int r = 0; r < 4; r++) begin
                for (int c = 0; c < 3; c++) begin
                    win_data[r*4 + c] <= win_data[r*4 + c + 1];
                end
            end
            for (int r = 0; r < 3; r++) begin
                win_data[r*4 + 3] <= ld_out[r];
            end
            win_data[15] <= pix_data;
        end
    end

    for (genvar i = 0; i < 3; i++) begin : g_line
        line_delay #(.depth(row_len - 4)) u_delay (
            .clk     (clk),
            .shift_en(shift_en),
            .din     (win_data[i*4 + 4]),
            .dout    (ld_out[i])
        );
    end

endmodule

// File: sources.f
hdl/bicubic_pkg.sv
hdl/bank_if.sv
hdl/line_delay.sv
hdl/window_gen.sv
hdl/result_store_ctrl.sv
hdl/result_banks.sv
hdl/bicubic_buffer.sv
testbench/bicubic_buffer_assertions.sv
testbench/tb_bicubic_buffer.sv

// File: testbench/bicubic_buffer_assertions.sv
`timescale 1ns/1ps

module bicubic_buffer_assertions (
    input logic                clk,
    input logic                rst_n,
    input logic                pix_valid,
    input logic                pix_ready,
    input logic                win_valid,
    input logic                win_ready,
    input bicubic_pkg::pixel_t win_data [16],
    input logic                res_ready,
    input logic                out_valid,
    input logic                out_ready,
    input bicubic_pkg::pixel_t out_data
);
    import bicubic_pkg::*;

    localparam int n_windows = img_width * img_height;
    localparam int n_outputs = 16 * n_windows;

    int     err_cnt = 0;
    int     pix_cnt;
    int     win_cnt;
    int     out_cnt;
    int     exp_pos;
    pixel_t exp_win [16];
    pixel_t exp_out;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_cnt <= 0;
            win_cnt <= 0;
            out_cnt <= 0;
        end else begin
            if (pix_valid && pix_ready)
                pix_cnt <= pix_cnt + 1;
            if (win_valid && win_ready)
                win_cnt <= win_cnt + 1;
            if (out_valid && out_ready)
                out_cnt <= out_cnt + 1;
        end
    end

    // window (r, c) covers source rows r..r+3, columns c..c+3
    always_comb begin
        int row;
        int col;
        int pos;
        row = win_cnt / img_width;
        col = win_cnt % img_width;
        exp_pos = preload_pixels + row * row_len + col;
        for (int k = 0; k < 16; k++) begin
            exp_win[k] = {12'(row + k / 4), 12'(col + k % 4)};
        end
        // order within a row is sub-line, column, sub-column
        row = out_cnt / (16 * img_width);
        pos = out_cnt % (16 * img_width);
        col = (pos % (4 * img_width)) / 4;
        exp_out = {8'(row), 8'(col), 8'((pos / (4 * img_width)) * 4 + pos % 4)};
    end

    for (genvar k = 0; k < 16; k++) begin : g_win
        a_win_data: assert property (@(posedge clk) disable iff (!rst_n)
            win_valid && win_ready |-> win_data[k] == exp_win[k])
        else begin
            err_cnt++;
            $error("FAIL win_data[%0d] exp %h got %h", k, $sampled(exp_win[k]),
                   $sampled(win_data[k]));
        end

        a_win_hold: assert property (@(posedge clk) disable iff (!rst_n)
            win_valid && !win_ready |=> win_valid && $stable(win_data[k]))
        else begin
            err_cnt++;
            $error("window dropped or changed while stalled, word %0d", k);
        end
    end

    a_win_pos: assert property (@(posedge clk) disable iff (!rst_n)
        win_valid |-> pix_cnt == exp_pos)
    else begin
        err_cnt++;
        $error("FAIL pix_cnt at win_valid exp %h got %h", $sampled(exp_pos),
               $sampled(pix_cnt));
    end

    a_win_count: assert property (@(posedge clk) disable iff (!rst_n)
        win_valid |-> win_cnt < n_windows)
    else begin
        err_cnt++;
        $error("window offered after the last source row");
    end

    a_out_order: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && out_ready |-> out_data == exp_out)
    else begin
        err_cnt++;
        $error("FAIL out_data exp %h got %h", $sampled(exp_out), $sampled(out_data));
    end

    a_out_count: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out_cnt < n_outputs)
    else begin
        err_cnt++;
        $error("output word offered beyond the last row");
    end

    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
    else begin
        err_cnt++;
        $error("output word dropped or changed while stalled");
    end

    a_in_reset: assert property (@(posedge clk)
        !rst_n |-> !win_valid && !out_valid && !res_ready && !pix_ready)
    else begin
        err_cnt++;
        $error("stream active while reset is asserted");
    end

    a_reset_exit: assert property (@(posedge clk)
        $rose(rst_n) |-> !win_valid && !out_valid && !res_ready)
    else begin
        err_cnt++;
        $error("streams not idle in the first cycle after reset");
    end

endmodule

bind bicubic_buffer bicubic_buffer_assertions chk0 (.*);

// File: testbench/tb_bicubic_buffer.sv
`timescale 1ns/1ps

module tb_bicubic_buffer;
    import bicubic_pkg::*;

    localparam int n_windows      = img_width * img_height;
    localparam int n_outputs      = 16 * n_windows;
    localparam int n_transfers    = total_pixels + n_windows + 2 * n_outputs;
    localparam int timeout_cycles = 40 * n_transfers;

    logic   clk = 1'b0;
    logic   rst_n;
    logic   pix_valid;
    logic   pix_ready;
    pixel_t pix_data;
    logic   win_valid;
    logic   win_ready;
    pixel_t win_data [16];
    logic   res_valid;
    logic   res_ready;
    pixel_t res_data;
    logic   out_valid;
    logic   out_ready;
    pixel_t out_data;
    int     out_seen = 0;

    always #50 clk = ~clk;

    bicubic_buffer dut0 (.*);

    task automatic advance_cycle;
        @(posedge clk);
        #1;
    endtask

    // pixel word: source row in [23:12], column in [11:0]
    task automatic send_pixels;
        for (int r = 0; r < img_height + 3; r++) begin
            for (int c = 0; c < row_len; c++) begin
                pix_valid = 1'b1;
                pix_data  = {12'(r), 12'(c)};
                @(negedge clk);
                while (!pix_ready)
                    @(negedge clk);
                advance_cycle();
                pix_valid = 1'b0;
                if ($urandom_range(3) == 0)
                    advance_cycle();
            end
        end
    endtask

    // interpolator model, one window then its 16 results
    task automatic serve_window;
        pixel_t base;
        logic   taken;
        taken = 1'b0;
        base  = '0;
        while (!taken) begin
            win_ready = ($urandom_range(2) != 0);
            @(negedge clk);
            taken = win_valid && win_ready;
            base  = win_data[0];
            advance_cycle();
        end
        win_ready = 1'b0;
        for (int k = 0; k < 16; k++) begin
            while ($urandom_range(3) == 0)
                advance_cycle();
            res_valid = 1'b1;
            res_data  = {base[19:12], base[7:0], 8'(k)};
            @(negedge clk);
            while (!res_ready)
                @(negedge clk);
            advance_cycle();
            res_valid = 1'b0;
        end
    endtask

    task automatic drain_outputs;
        forever begin
            out_ready = ($urandom_range(3) != 0);
            @(negedge clk);
            if (out_valid && out_ready)
                out_seen++;
            advance_cycle();
        end
    endtask

    initial begin
        void'($urandom(82));
        rst_n     = 1'b0;
        pix_valid = 1'b0;
        pix_data  = '0;
        win_ready = 1'b0;
        res_valid = 1'b0;
        res_data  = '0;
        out_ready = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        fork
            send_pixels();
            forever serve_window();
            drain_outputs();
        join_none
        wait (out_seen == n_outputs);
        repeat (4) advance_cycle();
        $display("error count: %0d assertion failures", dut0.chk0.err_cnt);
        if (dut0.chk0.err_cnt == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout after %0d cycles with %0d of %0d output words received",
                 timeout_cycles, out_seen, n_outputs);
        $display("error count: %0d assertion failures", dut0.chk0.err_cnt);
        $display("Simulation failed");
        $finish;
    end

endmodule
